// File: src/tluh_params.svh
// TileLink SRAM adapter parameters
`ifndef TLUH_PARAMS_SVH
`define TLUH_PARAMS_SVH

// TileLink bus geometry
`define TL_AW  32  // Byte address width on the A channel
`define TL_DW  32  // Data width of the A and D channels
`define TL_DBW 4   // Byte lanes in one data word
`define TL_SZW 2   // Width of the log2 size field
`define TL_AIW 8   // Source ID width, echoed back on D

// SRAM side, one SRAM word holds exactly one TL word
`define SRAM_AW 12  // Word address width, the TL byte bits are dropped

// Every FIFO in the adapter has this depth
`define OUTSTANDING 2  // Requests that may be in flight at once

// Request record holds kind, error flag, size and source
`define REQ_REC_W (1 + 1 + `TL_SZW + `TL_AIW)

// Pending-read record is just the byte mask of the read
`define SRAMREQ_W `TL_DBW

// Response record holds the masked read data and the error flag
`define RSP_REC_W (`TL_DW + 1)

`endif

// File: src/tluh_pkg.sv
// TileLink adapter types
package tluh_pkg;

  // A channel opcodes the adapter understands
  // Any other encoding on a_opcode is answered with an error
  typedef enum logic [2:0] {
    PutFullData    = 3'h0,  // Write, every addressed lane enabled
    PutPartialData = 3'h1,  // Write, any mask inside the addressed lanes
    Get            = 3'h4   // Read of the addressed lanes
  } tl_a_op_e;

  // D channel opcodes the adapter produces
  typedef enum logic [2:0] {
    AccessAck     = 3'h0,  // Answer to a write or an unknown opcode
    AccessAckData = 3'h1   // Answer to a read, carries d_data
  } tl_d_op_e;

  // Kind stored in the request record
  // It decides whether the D side waits for SRAM read data
  typedef enum logic {
    OpWrite = 1'b0,  // No data comes back from the SRAM
    OpRead  = 1'b1   // Response waits for the response FIFO
  } req_kind_e;

endpackage

// File: src/tluh_req_check.sv
// TileLink A request checker
`include "tluh_params.svh"

module tluh_req_check #(
  parameter bit BYTE_ACCESS  = 1'b1,  // Allow sub-word and partial writes
  parameter bit ERR_ON_WRITE = 1'b0,  // Every write is answered with an error
  parameter bit ERR_ON_READ  = 1'b0   // Every read is answered with an error
) (
  input  logic                                  a_valid_i,
  input  logic [$bits(tluh_pkg::tl_a_op_e)-1:0] a_opcode_i,  // Raw so unknown codes can appear
  input  logic [`TL_SZW-1:0]                    a_size_i,
  input  logic [`TL_AIW-1:0]                    a_source_i,
  input  logic [`TL_AW-1:0]                     a_address_i,
  input  logic [`TL_DBW-1:0]                    a_mask_i,
  input  logic [`TL_DW-1:0]                     a_data_i,
  input  logic                                  reqfifo_ready_i,  // Request FIFO has room
  output logic                                  req_o,
  output logic                                  we_o,
  output logic [`SRAM_AW-1:0]                   addr_o,
  output logic [`TL_DW-1:0]                     wdata_o,
  output logic [`TL_DW-1:0]                     wmask_o,
  output logic                                  err_o,
  output logic [`REQ_REC_W-1:0]                 req_rec_o,
  output logic [`SRAMREQ_W-1:0]                 mask_rec_o
);
  import tluh_pkg::*;

  localparam int unsigned LSB_W = $clog2(`TL_DBW);  // Byte offset bits inside a word

  logic               is_get;
  logic               is_put_full;
  logic               is_write;
  logic               op_err;
  logic               size_err;
  logic               align_err;
  logic               mask_err;
  logic               wr_attr_err;
  logic               wr_vld_err;
  logic               rd_vld_err;
  logic [LSB_W-1:0]   byte_off;
  logic [`TL_DBW-1:0] lanes;  // Lanes covered by address and size
  req_kind_e          kind;

  assign byte_off    = a_address_i[LSB_W-1:0];
  assign is_get      = (a_opcode_i == Get);
  assign is_put_full = (a_opcode_i == PutFullData);
  assign is_write    = is_put_full | (a_opcode_i == PutPartialData);

  assign op_err   = ~(is_get | is_write);  // Unknown opcode
  assign size_err = (a_size_i > LSB_W);    // Nothing wider than one TL word

  // Addressed lanes and alignment per size
  always_comb begin
    lanes     = '1;
    align_err = 1'b0;
    case (a_size_i)
      2'd0: lanes = `TL_DBW'(1) << byte_off;  // Single byte, any offset
      2'd1: begin
        lanes     = `TL_DBW'(3) << {byte_off[LSB_W-1:1], 1'b0};
        align_err = byte_off[0];  // Half word must sit on an even byte
      end
      2'd2: align_err = |byte_off;  // Full word must be word aligned
      default: lanes = '1;  // Oversize is already flagged by size_err
    endcase
  end

  // Mask may not leave the lanes, and a full put must fill them
  assign mask_err = (|(a_mask_i & ~lanes)) | (is_put_full & (a_mask_i != lanes));

  // Without byte access only full-word writes are legal
  assign wr_attr_err = ~BYTE_ACCESS & is_write & ((a_mask_i != '1) | (a_size_i != LSB_W));
  assign wr_vld_err  = ERR_ON_WRITE & is_write;
  assign rd_vld_err  = ERR_ON_READ & is_get;

  assign err_o = op_err | size_err | align_err | mask_err |
                 wr_attr_err | wr_vld_err | rd_vld_err;

  // An errored request never reaches the SRAM
  assign req_o  = a_valid_i & reqfifo_ready_i & ~err_o;
  assign we_o   = is_write;
  assign addr_o = a_address_i[LSB_W +: `SRAM_AW];  // Word address, upper bits alias

  // Byte mask to bit mask, unmasked data is forced to zero
  always_comb begin
    for (int i = 0; i < `TL_DBW; i++) begin
      wmask_o[8*i +: 8] = {8{a_mask_i[i]}};
    end
  end
  assign wdata_o = a_data_i & wmask_o;

  // Unknown opcodes are recorded as writes so they get an AccessAck
  assign kind       = is_get ? OpRead : OpWrite;
  assign req_rec_o  = {kind, err_o, a_size_i, a_source_i};
  assign mask_rec_o = a_mask_i;  // Needed again when read data returns

endmodule

// File: src/tluh_sync_fifo.sv
// Synchronous FIFO with pass-through
module tluh_sync_fifo #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2,
  parameter bit          PASS  = 1'b0  // Empty FIFO forwards a write in the same cycle
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [WIDTH-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [WIDTH-1:0] rdata_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);  // Must hold the value DEPTH

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wptr;
  logic [PTR_W-1:0] rptr;
  logic [CNT_W-1:0] count;  // Entries held in mem
  logic             empty;
  logic             bypass;
  logic             push;
  logic             pop;
  logic             store;
  logic             drain;

  assign empty    = (count == '0);
  assign wready_o = (count != CNT_W'(DEPTH));

  // In pass mode the write data is presented straight away when nothing is queued
  assign bypass   = PASS & empty & wvalid_i;
  assign rvalid_o = ~empty | bypass;
  assign rdata_o  = bypass ? wdata_i : mem[rptr];

  assign push  = wvalid_i & wready_o;
  assign pop   = rvalid_o & rready_i;
  assign store = push & ~(bypass & pop);  // A bypassed word taken at once is never stored
  assign drain = pop & ~empty;            // Only a stored word moves the read pointer

  // Pointer advance with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (store) begin
        wptr <= ptr_inc(wptr);
      end
      if (drain) begin
        rptr <= ptr_inc(rptr);
      end
      count <= count + CNT_W'(store) - CNT_W'(drain);  // Both at once keeps the count
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (store) begin
      mem[wptr] <= wdata_i;
    end
  end

endmodule

// File: src/tluh_rsp_assembler.sv
// TileLink D channel response assembler
`include "tluh_params.svh"

module tluh_rsp_assembler (
  input  logic [`REQ_REC_W-1:0] req_rec_i,        // Head of the request FIFO
  input  logic                  reqfifo_valid_i,
  input  logic [`RSP_REC_W-1:0] rsp_rec_i,        // Head of the response FIFO
  input  logic                  rspfifo_valid_i,
  input  logic [`TL_DW-1:0]     sram_rdata_i,
  input  logic                  sram_rvalid_i,
  input  logic                  sram_rerror_i,    // Uncorrectable read error
  input  logic [`SRAMREQ_W-1:0] mask_rec_i,       // Byte mask of the oldest pending read
  input  logic                  d_ready_i,
  output logic                  d_valid_o,
  output tluh_pkg::tl_d_op_e    d_opcode_o,
  output logic [`TL_SZW-1:0]    d_size_o,
  output logic [`TL_AIW-1:0]    d_source_o,
  output logic [`TL_DW-1:0]     d_data_o,
  output logic                  d_error_o,
  output logic [`RSP_REC_W-1:0] rsp_rec_o,
  output logic                  reqfifo_pop_o,
  output logic                  rspfifo_pop_o,
  output logic                  sramreqfifo_pop_o
);
  import tluh_pkg::*;

  req_kind_e          rec_kind;
  logic               rec_err;
  logic [`TL_SZW-1:0] rec_size;
  logic [`TL_AIW-1:0] rec_source;
  logic [`TL_DW-1:0]  rsp_data;
  logic               rsp_err;
  logic [`TL_DW-1:0]  rmask;
  logic               clean_read;  // Read that did go to the SRAM
  logic               d_ack;

  // Unpack the request record, same order as the checker packs it
  assign rec_kind   = req_kind_e'(req_rec_i[`REQ_REC_W-1]);
  assign rec_err    = req_rec_i[`REQ_REC_W-2];
  assign rec_size   = req_rec_i[`TL_AIW +: `TL_SZW];
  assign rec_source = req_rec_i[`TL_AIW-1:0];

  assign {rsp_data, rsp_err} = rsp_rec_i;

  // Only the requested bytes of the read word go back to the host
  always_comb begin
    for (int i = 0; i < `TL_DBW; i++) begin
      rmask[8*i +: 8] = {8{mask_rec_i[i]}};
    end
  end
  assign rsp_rec_o = {sram_rdata_i & rmask, sram_rerror_i};

  assign clean_read = (rec_kind == OpRead) & ~rec_err;

  // Writes and errored requests answer at once, clean reads wait for data
  assign d_valid_o = reqfifo_valid_i & (~clean_read | rspfifo_valid_i);

  // Errored Get still answers with AccessAckData
  assign d_opcode_o = (rec_kind == OpRead) ? AccessAckData : AccessAck;
  assign d_size_o   = rec_size;    // Echoed from the request
  assign d_source_o = rec_source;
  assign d_data_o   = (clean_read & rspfifo_valid_i) ? rsp_data : '0;
  assign d_error_o  = d_valid_o & (rec_err | (clean_read & rsp_err));

  assign d_ack = d_valid_o & d_ready_i;

  assign reqfifo_pop_o     = d_ack;               // Every response retires one request
  assign rspfifo_pop_o     = d_ack & clean_read;  // Only clean reads own response data
  assign sramreqfifo_pop_o = sram_rvalid_i;       // Mask is consumed as data returns

endmodule

// File: src/tluh_sram_adapter.sv
// TileLink-UL to SRAM adapter
`include "tluh_params.svh"

module tluh_sram_adapter #(
  parameter bit BYTE_ACCESS  = 1'b1,  // Sub-word writes allowed
  parameter bit ERR_ON_WRITE = 1'b0,  // Reject all writes
  parameter bit ERR_ON_READ  = 1'b0   // Reject all reads
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,

  // TileLink A channel
  input  logic                                  a_valid_i,
  output logic                                  a_ready_o,
  input  logic [$bits(tluh_pkg::tl_a_op_e)-1:0] a_opcode_i,
  input  logic [`TL_SZW-1:0]                    a_size_i,
  input  logic [`TL_AIW-1:0]                    a_source_i,
  input  logic [`TL_AW-1:0]                     a_address_i,
  input  logic [`TL_DBW-1:0]                    a_mask_i,
  input  logic [`TL_DW-1:0]                     a_data_i,

  // TileLink D channel
  output logic                                  d_valid_o,
  input  logic                                  d_ready_i,
  output tluh_pkg::tl_d_op_e                    d_opcode_o,
  output logic [`TL_SZW-1:0]                    d_size_o,
  output logic [`TL_AIW-1:0]                    d_source_o,
  output logic [`TL_DW-1:0]                     d_data_o,
  output logic                                  d_error_o,

  // SRAM port, reads return in order without back-pressure
  output logic                                  req_o,
  input  logic                                  gnt_i,
  output logic                                  we_o,
  output logic [`SRAM_AW-1:0]                   addr_o,
  output logic [`TL_DW-1:0]                     wdata_o,
  output logic [`TL_DW-1:0]                     wmask_o,
  input  logic [`TL_DW-1:0]                     rdata_i,
  input  logic                                  rvalid_i,
  input  logic                                  rerror_i
);

  logic                  err;  // Current A request fails a check
  logic                  a_ack;

  logic [`REQ_REC_W-1:0] req_rec;
  logic                  reqfifo_wvalid;
  logic                  reqfifo_wready;
  logic                  reqfifo_rvalid;
  logic                  reqfifo_rready;
  logic [`REQ_REC_W-1:0] reqfifo_rdata;

  logic [`SRAMREQ_W-1:0] mask_rec;
  logic                  sramreqfifo_wvalid;
  logic                  sramreqfifo_wready;
  logic                  sramreqfifo_rvalid;
  logic                  sramreqfifo_rready;
  logic [`SRAMREQ_W-1:0] sramreqfifo_rdata;

  logic [`RSP_REC_W-1:0] rspfifo_wdata;
  logic                  rspfifo_wvalid;
  logic                  rspfifo_rvalid;
  logic                  rspfifo_rready;
  logic [`RSP_REC_W-1:0] rspfifo_rdata;

  // Errored requests are accepted without a grant, they never touch the SRAM
  assign a_ready_o = (gnt_i | err) & reqfifo_wready & sramreqfifo_wready;
  assign a_ack     = a_valid_i & a_ready_o;

  assign reqfifo_wvalid     = a_ack;                  // Every accepted request is tracked
  assign sramreqfifo_wvalid = req_o & gnt_i & ~we_o;  // Only granted reads wait for data
  assign rspfifo_wvalid     = rvalid_i & sramreqfifo_rvalid;

  tluh_req_check #(
    .BYTE_ACCESS  (BYTE_ACCESS),
    .ERR_ON_WRITE (ERR_ON_WRITE),
    .ERR_ON_READ  (ERR_ON_READ)
  ) u_req_check (
    .a_valid_i       (a_valid_i),
    .a_opcode_i      (a_opcode_i),
    .a_size_i        (a_size_i),
    .a_source_i      (a_source_i),
    .a_address_i     (a_address_i),
    .a_mask_i        (a_mask_i),
    .a_data_i        (a_data_i),
    .reqfifo_ready_i (reqfifo_wready),
    .req_o           (req_o),
    .we_o            (we_o),
    .addr_o          (addr_o),
    .wdata_o         (wdata_o),
    .wmask_o         (wmask_o),
    .err_o           (err),
    .req_rec_o       (req_rec),
    .mask_rec_o      (mask_rec)
  );

  // Keeps kind, error, size and source until the D transfer
  tluh_sync_fifo #(
    .WIDTH (`REQ_REC_W),
    .DEPTH (`OUTSTANDING),
    .PASS  (1'b0)
  ) u_reqfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (reqfifo_wvalid),
    .wready_o (reqfifo_wready),
    .wdata_i  (req_rec),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (reqfifo_rready),
    .rdata_o  (reqfifo_rdata)
  );

  // Byte mask of each granted read until its data is back
  tluh_sync_fifo #(
    .WIDTH (`SRAMREQ_W),
    .DEPTH (`OUTSTANDING),
    .PASS  (1'b0)
  ) u_sramreqfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (sramreqfifo_wvalid),
    .wready_o (sramreqfifo_wready),
    .wdata_i  (mask_rec),
    .rvalid_o (sramreqfifo_rvalid),
    .rready_i (sramreqfifo_rready),
    .rdata_o  (sramreqfifo_rdata)
  );

  // Catches read data while D is stalled, the depth bound means it never overflows
  tluh_sync_fifo #(
    .WIDTH (`RSP_REC_W),
    .DEPTH (`OUTSTANDING),
    .PASS  (1'b1)
  ) u_rspfifo (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wvalid_i (rspfifo_wvalid),
    .wready_o (),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

  tluh_rsp_assembler u_rsp_assembler (
    .req_rec_i         (reqfifo_rdata),
    .reqfifo_valid_i   (reqfifo_rvalid),
    .rsp_rec_i         (rspfifo_rdata),
    .rspfifo_valid_i   (rspfifo_rvalid),
    .sram_rdata_i      (rdata_i),
    .sram_rvalid_i     (rvalid_i),
    .sram_rerror_i     (rerror_i),
    .mask_rec_i        (sramreqfifo_rdata),
    .d_ready_i         (d_ready_i),
    .d_valid_o         (d_valid_o),
    .d_opcode_o        (d_opcode_o),
    .d_size_o          (d_size_o),
    .d_source_o        (d_source_o),
    .d_data_o          (d_data_o),
    .d_error_o         (d_error_o),
    .rsp_rec_o         (rspfifo_wdata),
    .reqfifo_pop_o     (reqfifo_rready),
    .rspfifo_pop_o     (rspfifo_rready),
    .sramreqfifo_pop_o (sramreqfifo_rready)
  );

endmodule

// File: bench/tb_sram_model.sv
// Behavioral single-port SRAM
`include "tluh_params.svh"

module tb_sram_model #(
  parameter int unsigned         WORDS    = 4096,
  parameter logic [`SRAM_AW-1:0] ERR_WORD = 12'h0FF  // Byte address 0x3FC on the TL side
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  output logic                gnt_o,
  input  logic                we_i,
  input  logic [`SRAM_AW-1:0] addr_i,
  input  logic [`TL_DW-1:0]   wdata_i,
  input  logic [`TL_DW-1:0]   wmask_i,
  output logic [`TL_DW-1:0]   rdata_o,
  output logic                rvalid_o,
  output logic                rerror_o
);

  logic [`TL_DW-1:0] mem [WORDS];
  int                seed = 43297;  // Fixed so the grant pattern repeats

  // Every word starts with its own address in both halves
  initial begin
    for (int w = 0; w < WORDS; w++) begin
      mem[w] = {4'hA, 12'(w), 4'h5, 12'(w)};
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rerror_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      gnt_o    <= ($random(seed) & 3) != 0;  // Grant on roughly three cycles in four
      rvalid_o <= 1'b0;
      rerror_o <= 1'b0;
      if (req_i && gnt_o) begin
        if (we_i) begin
          mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
        end else begin
          rvalid_o <= 1'b1;  // Data follows one cycle after the grant
          rdata_o  <= mem[addr_i];
          rerror_o <= (addr_i == ERR_WORD);  // Uncorrectable error on the marked word
        end
      end
    end
  end

endmodule

// File: bench/tluh_sram_adapter_assertions.sv
// Adapter protocol assertions
`include "tluh_params.svh"

module tluh_sram_adapter_assertions (
  input logic                        clk_i,
  input logic                        rst_i,
  input logic                        a_valid_i,
  input logic                        a_ready_i,
  input logic [2:0]                  a_opcode_i,
  input logic [`TL_SZW-1:0]          a_size_i,
  input logic [1:0]                  a_offset_i,  // Byte offset of the A address
  input logic [`TL_DBW-1:0]          a_mask_i,
  input logic                        d_valid_i,
  input logic                        d_ready_i,
  input logic [3+`TL_SZW+`TL_AIW+`TL_DW:0] d_payload_i,  // Opcode, size, source, data, error
  input logic                        req_i
);
  import tluh_pkg::*;

  int unsigned        outstanding;  // Accepted requests still waiting for D
  int unsigned        assert_fails = 0;
  logic [`TL_DBW-1:0] a_lanes;      // Lanes that the A size and offset cover
  logic               a_aligned;
  logic               a_legal;      // A request passes every TileLink-UL rule

  always @(posedge clk_i) begin
    if (rst_i) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + 32'(a_valid_i & a_ready_i) - 32'(d_valid_i & d_ready_i);
    end
  end

  always_comb begin
    case (a_size_i)
      2'd0:    a_lanes = 4'b0001 << a_offset_i;
      2'd1:    a_lanes = 4'b0011 << a_offset_i;
      default: a_lanes = 4'b1111;
    endcase
  end

  // Sizes above one word never count as aligned
  assign a_aligned = (a_size_i == 2'd0) ||
                     ((a_size_i == 2'd1) && !a_offset_i[0]) ||
                     ((a_size_i == 2'd2) && (a_offset_i == 2'd0));

  assign a_legal = ((a_opcode_i == Get) || (a_opcode_i == PutFullData) ||
                    (a_opcode_i == PutPartialData)) &&
                   a_aligned &&
                   ((a_mask_i & ~a_lanes) == '0) &&
                   ((a_opcode_i != PutFullData) || (a_mask_i == a_lanes));

  d_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    d_valid_i && !d_ready_i |=> d_valid_i && $stable(d_payload_i))
    else begin
      $error("D response dropped or changed before d_ready");
      assert_fails++;
    end

  no_err_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |-> a_valid_i && a_legal)
    else begin
      $error("SRAM request issued for an errored A request");
      assert_fails++;
    end

  d_after_a: assert property (@(posedge clk_i) disable iff (rst_i) d_valid_i |-> outstanding != 0)
    else begin
      $error("D response without an accepted A request");
      assert_fails++;
    end

endmodule

bind tluh_sram_adapter tluh_sram_adapter_assertions u_assertions (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .a_valid_i   (a_valid_i),
  .a_ready_i   (a_ready_o),
  .a_opcode_i  (a_opcode_i),
  .a_size_i    (a_size_i),
  .a_offset_i  (a_address_i[1:0]),
  .a_mask_i    (a_mask_i),
  .d_valid_i   (d_valid_o),
  .d_ready_i   (d_ready_i),
  .d_payload_i ({d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o}),
  .req_i       (req_o)
);

// File: bench/tb_tluh_sram_adapter.sv
// TileLink SRAM adapter testbench
`include "tluh_params.svh"

module tb_tluh_sram_adapter;
  import tluh_pkg::*;

  localparam int NUM_DIR   = 11;            // Directed entries at the head of the table
  localparam int NUM_TESTS = NUM_DIR + 40;  // Random mixed requests follow them

  logic                 clk_i = 1'b0;
  logic                 rst_i;
  logic                 a_valid_i;
  logic                 a_ready_o;
  logic [2:0]           a_opcode_i;
  logic [`TL_SZW-1:0]   a_size_i;
  logic [`TL_AIW-1:0]   a_source_i;
  logic [`TL_AW-1:0]    a_address_i;
  logic [`TL_DBW-1:0]   a_mask_i;
  logic [`TL_DW-1:0]    a_data_i;
  logic                 d_valid_o;
  logic                 d_ready_i;
  tl_d_op_e             d_opcode_o;
  logic [`TL_SZW-1:0]   d_size_o;
  logic [`TL_AIW-1:0]   d_source_o;
  logic [`TL_DW-1:0]    d_data_o;
  logic                 d_error_o;
  logic                 req_o;
  logic                 gnt_i;
  logic                 we_o;
  logic [`SRAM_AW-1:0]  addr_o;
  logic [`TL_DW-1:0]    wdata_o;
  logic [`TL_DW-1:0]    wmask_o;
  logic [`TL_DW-1:0]    rdata_i;
  logic                 rvalid_i;
  logic                 rerror_i;

  // Stimulus and expected values, one slot per test
  string       t_name     [NUM_TESTS];
  logic [2:0]  t_op       [NUM_TESTS];
  logic [31:0] t_addr     [NUM_TESTS];
  logic [1:0]  t_size     [NUM_TESTS];
  logic [3:0]  t_mask     [NUM_TESTS];
  logic [31:0] t_data     [NUM_TESTS];
  logic [2:0]  t_exp_op   [NUM_TESTS];
  logic [31:0] t_exp_data [NUM_TESTS];
  logic        t_exp_err  [NUM_TESTS];
  logic [31:0] ref_mem    [4096];  // What the SRAM should hold, request by request
  int          pending_q  [$];     // Accepted requests in the order D must answer them
  int          seed = 43297;
  int          err_count = 0;
  int          passed = 0;
  int          failed = 0;
  int          resp_count = 0;

  tluh_sram_adapter #(.BYTE_ACCESS(1'b1), .ERR_ON_WRITE(1'b0), .ERR_ON_READ(1'b0)) dut0 (.*);

  tb_sram_model u_sram (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .req_i    (req_o),
    .gnt_o    (gnt_i),
    .we_i     (we_o),
    .addr_i   (addr_o),
    .wdata_i  (wdata_o),
    .wmask_i  (wmask_o),
    .rdata_o  (rdata_i),
    .rvalid_o (rvalid_i),
    .rerror_o (rerror_i)
  );

  always #4 clk_i = ~clk_i;

  task automatic compare_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s %s: expected %h actual %h", test, field, expected, actual);
      err_count++;
    end
  endtask

  task automatic set_entry(input int i, input string name, input logic [2:0] op,
                           input logic [31:0] addr, input logic [1:0] size,
                           input logic [3:0] mask, input logic [31:0] data,
                           input logic [2:0] exp_op, input logic [31:0] exp_data,
                           input logic exp_err);
    t_name[i]     = name;
    t_op[i]       = op;
    t_addr[i]     = addr;
    t_size[i]     = size;
    t_mask[i]     = mask;
    t_data[i]     = data;
    t_exp_op[i]   = exp_op;
    t_exp_data[i] = exp_data;
    t_exp_err[i]  = exp_err;
  endtask

  // Lanes that a request of this size touches at this byte offset
  function automatic logic [3:0] lanes_for(input logic [1:0] size, input logic [1:0] off);
    case (size)
      2'd0:    lanes_for = 4'b0001 << off;
      2'd1:    lanes_for = 4'b0011 << off;
      default: lanes_for = 4'b1111;
    endcase
  endfunction

  function automatic logic [31:0] bit_mask(input logic [3:0] mask);
    for (int b = 0; b < 4; b++) begin
      bit_mask[8*b +: 8] = {8{mask[b]}};
    end
  endfunction

  // Legal request in words 0x40 to 0x7F, well away from the error word
  task automatic make_random_entry(input int i);
    logic [31:0] r;
    logic [1:0]  off;
    r         = $random(seed);
    t_name[i] = $sformatf("random_%0d", i - NUM_DIR);
    t_size[i] = r[3:2] % 2'd3;
    off       = (t_size[i] == 2'd0) ? r[11:10] : (t_size[i] == 2'd1) ? {r[10], 1'b0} : 2'd0;
    t_addr[i] = {18'd0, 6'b000001, r[9:4], off};
    t_op[i]   = (r[1:0] == 2'd0) ? PutFullData : (r[1:0] == 2'd1) ? PutPartialData : Get;
    t_mask[i] = lanes_for(t_size[i], off);
    if (t_op[i] == PutPartialData && (t_mask[i] & r[15:12]) != 4'd0) begin
      t_mask[i] = t_mask[i] & r[15:12];  // Partial put keeps only some lanes
    end
    t_data[i] = $random(seed);
  endtask

  task automatic build_table();
    logic [31:0] bm;
    int          w;
    set_entry(0, "put_full", PutFullData, 'h100, 2, 'hF, 'h1234_5678, AccessAck, 0, 0);
    set_entry(1, "get_full", Get, 'h100, 2, 'hF, 0, AccessAckData, 'h1234_5678, 0);
    set_entry(2, "put_partial", PutPartialData, 'h102, 1, 'hC, 'hABCD_0000, AccessAck, 0, 0);
    set_entry(3, "get_merged", Get, 'h100, 2, 'hF, 0, AccessAckData, 'hABCD_5678, 0);
    set_entry(4, "get_one_byte", Get, 'h101, 0, 'h2, 0, AccessAckData, 'h0000_5600, 0);
    set_entry(5, "put_misaligned", PutFullData, 'h102, 2, 'hF, 'hDEAD_BEEF, AccessAck, 0, 1);
    set_entry(6, "put_mask_outside", PutPartialData, 'h100, 1, 'h4, 'h5555_5555, AccessAck, 0, 1);
    set_entry(7, "put_full_part_mask", PutFullData, 'h100, 2, 'h7, 'h1111_1111, AccessAck, 0, 1);
    set_entry(8, "bad_opcode", 3'h7, 'h100, 2, 'hF, 'hFFFF_FFFF, AccessAck, 0, 1);
    set_entry(9, "get_after_errors", Get, 'h100, 2, 'hF, 0, AccessAckData, 'hABCD_5678, 0);
    set_entry(10, "get_rerror", Get, 'h3FC, 2, 'hF, 0, AccessAckData, 'hA0FF_50FF, 1);
    for (int k = 0; k < 4096; k++) begin
      ref_mem[k] = {4'hA, 12'(k), 4'h5, 12'(k)};  // Same start pattern as the SRAM model
    end
    // Walk the table in issue order so every read sees all earlier writes
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (i >= NUM_DIR) begin
        make_random_entry(i);
      end
      w  = int'(t_addr[i][13:2]);
      bm = bit_mask(t_mask[i]);
      if (i >= NUM_DIR) begin
        t_exp_op[i]   = (t_op[i] == Get) ? AccessAckData : AccessAck;
        t_exp_data[i] = ref_mem[w] & bm;  // Unrequested lanes read as zero
        t_exp_err[i]  = 1'b0;
      end
      if (t_op[i] != Get && !t_exp_err[i]) begin
        ref_mem[w] = (ref_mem[w] & ~bm) | (t_data[i] & bm);
      end
    end
  endtask

  task automatic check_response();
    int idx;
    int errors_before;
    errors_before = err_count;
    if (pending_q.size() == 0) begin
      $display("unexpected response on the D channel with no request outstanding");
      err_count++;
    end else begin
      idx = pending_q.pop_front();
      compare_value(t_name[idx], "d_opcode", 32'(t_exp_op[idx]), 32'(d_opcode_o));
      compare_value(t_name[idx], "d_size", 32'(t_size[idx]), 32'(d_size_o));
      compare_value(t_name[idx], "d_source", 32'(idx), 32'(d_source_o));  // Source is the index
      compare_value(t_name[idx], "d_error", 32'(t_exp_err[idx]), 32'(d_error_o));
      if (t_exp_op[idx] == AccessAckData) begin
        compare_value(t_name[idx], "d_data", t_exp_data[idx], d_data_o);
      end
      if (err_count == errors_before) begin
        passed++;
        $display("test %2d %-20s ok", idx, t_name[idx]);
      end else begin
        failed++;
        $display("test %2d %-20s failed", idx, t_name[idx]);
      end
      resp_count++;
    end
  endtask

  // D side with random stalls, a response is taken on the edge after this negedge
  initial begin
    wait (rst_i === 1'b0);
    forever begin
      @(posedge clk_i);
      #1;
      d_ready_i = ($random(seed) & 3) != 0;
      @(negedge clk_i);
      if (d_valid_o && d_ready_i) begin
        check_response();
      end
    end
  end

  initial begin
    repeat (NUM_TESTS * 50) @(posedge clk_i);
    $display("timeout: only %0d of %0d responses arrived in time", resp_count, NUM_TESTS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    int total_errors;
    rst_i       = 1'b1;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_size_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_mask_i    = '0;
    a_data_i    = '0;
    d_ready_i   = 1'b0;
    build_table();
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    for (int i = 0; i < NUM_TESTS; i++) begin
      a_valid_i   = 1'b1;  // Payload stays put until the transfer
      a_opcode_i  = t_op[i];
      a_size_i    = t_size[i];
      a_source_i  = 8'(i);
      a_address_i = t_addr[i];
      a_mask_i    = t_mask[i];
      a_data_i    = t_data[i];
      @(negedge clk_i);
      while (!a_ready_o) begin
        @(negedge clk_i);
      end
      pending_q.push_back(i);
      @(posedge clk_i);
      #1;
    end
    a_valid_i = 1'b0;
    wait (resp_count == NUM_TESTS);
    repeat (4) @(posedge clk_i);  // Room for any stray response to show up
    total_errors = err_count + int'(dut0.u_assertions.assert_fails);
    $display("tests %0d, passed %0d, failed %0d, check errors %0d, assertion failures %0d",
             NUM_TESTS, passed, failed, err_count, dut0.u_assertions.assert_fails);
    if (total_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: tluh_sram_adapter.f
+incdir+src
src/tluh_pkg.sv
src/tluh_req_check.sv
src/tluh_sync_fifo.sv
src/tluh_rsp_assembler.sv
src/tluh_sram_adapter.sv
bench/tb_sram_model.sv
bench/tluh_sram_adapter_assertions.sv
bench/tb_tluh_sram_adapter.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_tluh_sram_adapter
FILELIST  ?= tluh_sram_adapter.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard src/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
